/* hdl/fir_pkg.sv */
package fir_pkg;

  // filter geometry
  localparam int unsigned NUM_FIR       = 4;  // lanes, power of two only
  localparam int unsigned TAPS_PER_LANE = 4;
  localparam int unsigned NUM_TAPS      = NUM_FIR * TAPS_PER_LANE;

  // index widths
  localparam int unsigned TAP_IDX_W  = $clog2(NUM_TAPS);       // global tap index
  localparam int unsigned LANE_IDX_W = $clog2(NUM_FIR);        // upper part of tap index
  localparam int unsigned TAP_SEL_W  = $clog2(TAPS_PER_LANE);  // tap inside one lane

  // datapath widths
  localparam int unsigned SAMPLE_W   = 16;
  localparam int unsigned COEF_W     = 16;
  localparam int unsigned LANE_ACC_W = SAMPLE_W + COEF_W + TAP_SEL_W;   // 34
  localparam int unsigned RESULT_W   = LANE_ACC_W + LANE_IDX_W;         // 36
  localparam int unsigned OVR_W      = 16;

  // strobe to result, fixed
  localparam int unsigned LATENCY = TAPS_PER_LANE + 2;

  // register map, byte addresses
  localparam logic [7:0] COEF_SPAN    = 8'(NUM_TAPS * 4);  // 0x00..0x3c
  localparam logic [7:0] ADDR_OVERRUN = 8'h40;
  localparam logic [7:0] ADDR_RESULT  = 8'h44;

  typedef logic signed [SAMPLE_W-1:0]   sample_t;
  typedef logic signed [COEF_W-1:0]     coef_t;
  typedef logic signed [LANE_ACC_W-1:0] lane_acc_t;
  typedef logic signed [RESULT_W-1:0]   result_t;

  // one coefficient update, broadcast to every lane
  typedef struct packed {
    logic                 valid;
    logic [TAP_IDX_W-1:0] idx;
    coef_t                coef;
  } coef_wr_t;

  // taps of one lane, element 0 is the newest of the slice
  typedef sample_t [TAPS_PER_LANE-1:0] segment_t;

endpackage

/* hdl/tlul_pkg.sv */
package tlul_pkg;

  // reduced channel widths
  localparam int unsigned TL_AW  = 8;
  localparam int unsigned TL_DW  = 32;
  localparam int unsigned TL_OPW = 3;

  // a channel opcodes
  localparam logic [TL_OPW-1:0] OP_PUT_FULL = 3'h0;
  localparam logic [TL_OPW-1:0] OP_GET      = 3'h4;

  // d channel opcodes
  localparam logic [TL_OPW-1:0] OP_ACK      = 3'h0;
  localparam logic [TL_OPW-1:0] OP_ACK_DATA = 3'h1;

  // host to device, request channel plus response ready
  typedef struct packed {
    logic              a_valid;
    logic [TL_OPW-1:0] a_opcode;
    logic [TL_AW-1:0]  a_address;
    logic [TL_DW-1:0]  a_data;
    logic              d_ready;
  } tl_h2d_t;

  // device to host, response channel plus request ready
  typedef struct packed {
    logic              a_ready;
    logic              d_valid;
    logic [TL_OPW-1:0] d_opcode;
    logic [TL_DW-1:0]  d_data;
    logic              d_error;
  } tl_d2h_t;

endpackage

/* hdl/fir_reg_port.sv */
module fir_reg_port (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  tlul_pkg::tl_h2d_t              tl_i,
  output tlul_pkg::tl_d2h_t              tl_o,
  output fir_pkg::coef_wr_t              coef_wr_o,
  input  logic [fir_pkg::OVR_W-1:0]      overrun_i,
  input  fir_pkg::result_t               result_i,
  input  logic                           result_valid_i
);

  // request decode
  logic                             accept;
  logic                             is_get;
  logic                             is_put;
  logic                             hit_coef;
  logic                             hit_ovr;
  logic                             hit_res;
  logic [fir_pkg::TAP_IDX_W-1:0]    a_idx;
  logic [tlul_pkg::TL_DW-1:0]       rd_data;
  logic                             req_err;

  // state
  fir_pkg::coef_t [fir_pkg::NUM_TAPS-1:0] shadow_q;  // readback copy of all taps
  logic [tlul_pkg::TL_DW-1:0]       last_res_q;
  fir_pkg::coef_wr_t                coef_wr_q;
  logic                             d_valid_q;       // also the pending flag
  logic [tlul_pkg::TL_OPW-1:0]      d_opcode_q;
  logic [tlul_pkg::TL_DW-1:0]       d_data_q;
  logic                             d_error_q;

  assign accept   = tl_i.a_valid && !d_valid_q;  // one request in flight
  assign is_get   = tl_i.a_opcode == tlul_pkg::OP_GET;
  assign is_put   = tl_i.a_opcode == tlul_pkg::OP_PUT_FULL;
  assign a_idx    = tl_i.a_address[fir_pkg::TAP_IDX_W+1:2];  // word index
  assign hit_coef = (tl_i.a_address < fir_pkg::COEF_SPAN) && (tl_i.a_address[1:0] == 2'b00);
  assign hit_ovr  = tl_i.a_address == fir_pkg::ADDR_OVERRUN;
  assign hit_res  = tl_i.a_address == fir_pkg::ADDR_RESULT;

  always_comb begin
    rd_data = '0;
    req_err = 1'b0;
    if (hit_coef) begin
      rd_data = {{(tlul_pkg::TL_DW-fir_pkg::COEF_W){shadow_q[a_idx][fir_pkg::COEF_W-1]}},
                 shadow_q[a_idx]};  // sign extended
    end else if (hit_ovr) begin
      rd_data = {{(tlul_pkg::TL_DW-fir_pkg::OVR_W){1'b0}}, overrun_i};
    end else if (hit_res) begin
      rd_data = last_res_q;
    end else begin
      req_err = 1'b1;  // unmapped
    end
    if (is_put && !hit_coef) req_err = 1'b1;  // status regs are read only
    if (!is_put && !is_get) req_err = 1'b1;   // unsupported opcode
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      shadow_q   <= '0;
      last_res_q <= '0;
      coef_wr_q  <= '0;
      d_valid_q  <= 1'b0;
      d_opcode_q <= tlul_pkg::OP_ACK;
      d_data_q   <= '0;
      d_error_q  <= 1'b0;
    end else begin
      coef_wr_q.valid <= 1'b0;  // single cycle broadcast
      if (result_valid_i) last_res_q <= result_i[tlul_pkg::TL_DW-1:0];
      if (d_valid_q && tl_i.d_ready) d_valid_q <= 1'b0;  // response taken
      if (accept) begin
        d_valid_q  <= 1'b1;
        d_opcode_q <= (is_get && !req_err) ? tlul_pkg::OP_ACK_DATA : tlul_pkg::OP_ACK;
        d_data_q   <= (is_get && !req_err) ? rd_data : '0;
        d_error_q  <= req_err;
        if (is_put && !req_err) begin
          shadow_q[a_idx] <= tl_i.a_data[fir_pkg::COEF_W-1:0];
          coef_wr_q       <= '{valid: 1'b1, idx: a_idx,
                               coef: tl_i.a_data[fir_pkg::COEF_W-1:0]};
        end
      end
    end
  end

  assign coef_wr_o = coef_wr_q;
  assign tl_o = '{a_ready: !d_valid_q, d_valid: d_valid_q, d_opcode: d_opcode_q,
                  d_data: d_data_q, d_error: d_error_q};

  // an untaken response stays up and unchanged, no second request slips in
  a_rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    d_valid_q && !tl_i.d_ready |=> d_valid_q && $stable({d_opcode_q, d_data_q, d_error_q}));

endmodule

/* hdl/fir_sample_line.sv */
module fir_sample_line (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  input  fir_pkg::sample_t                              sample_i,
  input  logic                                          sample_valid_i,
  input  logic                                          done_i,      // busy clear
  output fir_pkg::segment_t [fir_pkg::NUM_FIR-1:0]      segments_o,
  output logic                                          start_o,
  output logic [fir_pkg::OVR_W-1:0]                     overrun_o
);

  fir_pkg::sample_t [fir_pkg::NUM_TAPS-1:0] line_q;  // tap 0 newest
  logic                                     busy_q;
  logic                                     start_q;
  logic [fir_pkg::OVR_W-1:0]                ovr_q;
  logic                                     accept;
  logic                                     drop;

  assign accept = sample_valid_i && !busy_q;
  assign drop   = sample_valid_i && busy_q;  // lanes still running, not queued

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      line_q  <= '0;
      busy_q  <= 1'b0;
      start_q <= 1'b0;
      ovr_q   <= '0;
    end else begin
      start_q <= accept;  // lanes see the shifted line one cycle later
      if (accept) begin
        line_q <= {line_q[fir_pkg::NUM_TAPS-2:0], sample_i};
        busy_q <= 1'b1;
      end else if (done_i) begin
        busy_q <= 1'b0;
      end
      if (drop && (ovr_q != '1)) ovr_q <= ovr_q + 1'b1;  // saturate
    end
  end

  // slice the line, lane l gets taps l*TAPS_PER_LANE upward
  always_comb begin
    for (int l = 0; l < fir_pkg::NUM_FIR; l++) begin
      for (int t = 0; t < fir_pkg::TAPS_PER_LANE; t++) begin
        segments_o[l][t] = line_q[l*fir_pkg::TAPS_PER_LANE + t];
      end
    end
  end

  assign start_o   = start_q;
  assign overrun_o = ovr_q;

  // busy-clear from the sum stage must keep starts a full latency apart
  a_start_spacing: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    start_o |=> !start_o [*fir_pkg::LATENCY]);

endmodule

/* hdl/fir_lane.sv */
module fir_lane #(
  parameter int unsigned LANE = 0  // slice number, below NUM_FIR
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  fir_pkg::coef_wr_t   coef_wr_i,
  input  fir_pkg::segment_t   segment_i,
  input  logic                start_i,
  output fir_pkg::lane_acc_t  acc_o,
  output logic                done_o
);

  if (LANE >= fir_pkg::NUM_FIR) begin : g_bad_lane
    $error("fir_lane: LANE out of range");
  end

  fir_pkg::coef_t [fir_pkg::TAPS_PER_LANE-1:0] coef_q;  // own taps only
  fir_pkg::segment_t                seg_q;     // frozen copy for the whole run
  logic [fir_pkg::TAP_SEL_W-1:0]    cnt_q;
  logic                             running_q;
  fir_pkg::lane_acc_t               acc_q;
  logic                             done_q;
  logic                             lane_hit;
  fir_pkg::sample_t                 tap_sample;
  fir_pkg::coef_t                   tap_coef;
  logic signed [fir_pkg::SAMPLE_W+fir_pkg::COEF_W-1:0] prod;

  // upper index bits select the lane
  assign lane_hit = coef_wr_i.valid &&
    (coef_wr_i.idx[fir_pkg::TAP_IDX_W-1 -: fir_pkg::LANE_IDX_W] == fir_pkg::LANE_IDX_W'(LANE));

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      coef_q <= '0;
    end else if (lane_hit) begin
      coef_q[coef_wr_i.idx[fir_pkg::TAP_SEL_W-1:0]] <= coef_wr_i.coef;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) seg_q <= segment_i;
  end

  // tap 0 straight from the line at start, later taps from the copy
  always_comb begin
    if (start_i) begin
      tap_sample = segment_i[0];
    end else begin
      tap_sample = seg_q[cnt_q];
    end
    tap_coef = coef_q[cnt_q];  // counter rests at 0 between runs
    prod     = $signed(tap_sample) * $signed(tap_coef);
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      running_q <= 1'b0;
      cnt_q     <= '0;
      acc_q     <= '0;
      done_q    <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (start_i) begin
        acc_q     <= fir_pkg::lane_acc_t'(prod);  // first mac, restarts sum
        cnt_q     <= fir_pkg::TAP_SEL_W'(1);
        running_q <= 1'b1;
      end else if (running_q) begin
        acc_q <= acc_q + fir_pkg::lane_acc_t'(prod);
        cnt_q <= cnt_q + 1'b1;  // wraps to 0 after last tap
        if (cnt_q == fir_pkg::TAP_SEL_W'(fir_pkg::TAPS_PER_LANE-1)) begin
          running_q <= 1'b0;
          done_q    <= 1'b1;
        end
      end
    end
  end

  assign acc_o  = acc_q;
  assign done_o = done_q;

endmodule

/* hdl/fir_sum_stage.sv */
module fir_sum_stage (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  input  fir_pkg::lane_acc_t [fir_pkg::NUM_FIR-1:0]   acc_i,
  input  logic [fir_pkg::NUM_FIR-1:0]                 done_i,
  output fir_pkg::result_t                            result_o,
  output logic                                        result_valid_o,
  output logic                                        idle_o  // busy clear pulse
);

  logic             all_done;
  logic             any_done;
  fir_pkg::result_t sum;
  fir_pkg::result_t result_q;
  logic             valid_q;

  assign all_done = &done_i;
  assign any_done = |done_i;

  // adder over all partial sums, lanes sign extended
  always_comb begin
    sum = '0;
    for (int l = 0; l < fir_pkg::NUM_FIR; l++) begin
      sum = sum + fir_pkg::result_t'($signed(acc_i[l]));
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      result_q <= '0;
      valid_q  <= 1'b0;
    end else begin
      valid_q <= all_done;  // one cycle pulse, lanes done for one cycle
      if (all_done) result_q <= sum;
    end
  end

  assign result_o       = result_q;
  assign result_valid_o = valid_q;
  // result leaving frees the line for the next strobe
  assign idle_o         = valid_q;

  // lanes start together and run the same number of taps
  a_done_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    any_done |-> all_done);

endmodule

/* hdl/fir_parallel.sv */
module fir_parallel (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  fir_pkg::sample_t  sample_i,
  input  logic              sample_valid_i,
  input  tlul_pkg::tl_h2d_t tl_i,
  output tlul_pkg::tl_d2h_t tl_o,
  output fir_pkg::result_t  result_o,
  output logic              result_valid_o
);

  fir_pkg::coef_wr_t                              coef_wr;
  fir_pkg::segment_t  [fir_pkg::NUM_FIR-1:0]      segments;
  fir_pkg::lane_acc_t [fir_pkg::NUM_FIR-1:0]      lane_acc;
  logic [fir_pkg::NUM_FIR-1:0]                    lane_done;
  logic                                           start;
  logic                                           idle;
  logic [fir_pkg::OVR_W-1:0]                      overrun;

  fir_reg_port u_reg_port (
    .clk_i,
    .rst_n_i,
    .tl_i,
    .tl_o,
    .coef_wr_o      (coef_wr),
    .overrun_i      (overrun),
    .result_i       (result_o),
    .result_valid_i (result_valid_o)
  );

  fir_sample_line u_sample_line (
    .clk_i,
    .rst_n_i,
    .sample_i,
    .sample_valid_i,
    .done_i     (idle),
    .segments_o (segments),
    .start_o    (start),
    .overrun_o  (overrun)
  );

  // one lane per segment, coefficients picked by lane number
  for (genvar l = 0; l < fir_pkg::NUM_FIR; l++) begin : g_lane
    fir_lane #(.LANE(l)) u_lane (
      .clk_i,
      .rst_n_i,
      .coef_wr_i (coef_wr),
      .segment_i (segments[l]),
      .start_i   (start),
      .acc_o     (lane_acc[l]),
      .done_o    (lane_done[l])
    );
  end

  fir_sum_stage u_sum_stage (
    .clk_i,
    .rst_n_i,
    .acc_i          (lane_acc),
    .done_i         (lane_done),
    .result_o,
    .result_valid_o,
    .idle_o         (idle)
  );

endmodule

/* tb/fir_checker.sv */
module fir_checker (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  fir_pkg::sample_t  sample_i,
  input  logic              sample_valid_i,
  input  tlul_pkg::tl_h2d_t tl_h2d_i,
  input  tlul_pkg::tl_d2h_t tl_d2h_i,
  input  fir_pkg::result_t  result_i,
  input  logic              result_valid_i,
  output int                value_errs_o,
  output int                other_errs_o,
  output int                results_o,
  output int                responses_o
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int LAT = fir_pkg::TAPS_PER_LANE + 2;  // strobe to result
  localparam int N   = fir_pkg::NUM_TAPS;

  int          value_errs = 0;
  int          other_errs = 0;
  int          results = 0;
  int          responses = 0;
  int          cyc = 0;
  int          last_acc_cyc = -100;  // first strobe always taken
  int          drops_m = 0;
  int          idx;
  longint      coef_m [N];
  longint      hist_m [N];           // 0 is newest
  longint      exp_val_q [$];
  int          exp_due_q [$];
  longint      last_res_m = 0;
  longint      want;
  longint      sum;
  logic        rsp_pending = 1'b0;
  logic        exp_err;
  logic        exp_has_data;
  logic        coef_hit;
  logic [2:0]  exp_op;
  logic [31:0] exp_data;

  task automatic value_error(input string name, input longint got, input longint exp);
    value_errs++;
    $display("** Error at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
  endtask

  task automatic other_error(input string msg);
    other_errs++;
    $display("%0t ns: %s", $time, msg);
  endtask

  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cyc = 0;
      last_acc_cyc = -100;
      drops_m = 0;
      last_res_m = 0;
      rsp_pending = 1'b0;
      exp_val_q.delete();
      exp_due_q.delete();
      for (int k = 0; k < N; k++) begin
        coef_m[k] = 0;
        hist_m[k] = 0;
      end
    end else begin
      cyc++;
      // handshake flags follow the pending response
      if (tl_d2h_i.a_ready !== !rsp_pending)
        value_error("a_ready", tl_d2h_i.a_ready, !rsp_pending);
      if (tl_d2h_i.d_valid !== rsp_pending)
        value_error("d_valid", tl_d2h_i.d_valid, rsp_pending);
      if (tl_d2h_i.d_valid && tl_h2d_i.d_ready) begin
        responses++;
        if (!rsp_pending) begin
          other_error("response taken without an accepted request");
        end else begin
          rsp_pending = 1'b0;
          if (tl_d2h_i.d_error !== exp_err) value_error("d_error", tl_d2h_i.d_error, exp_err);
          if (tl_d2h_i.d_opcode !== exp_op) value_error("d_opcode", tl_d2h_i.d_opcode, exp_op);
          if (exp_has_data && tl_d2h_i.d_data !== exp_data)
            value_error("d_data", tl_d2h_i.d_data, exp_data);
        end
      end
      // request decode from the register map, state as it was before this edge
      if (tl_h2d_i.a_valid && tl_d2h_i.a_ready) begin
        rsp_pending = 1'b1;
        idx = int'(tl_h2d_i.a_address >> 2);
        coef_hit = (tl_h2d_i.a_address < 8'(N * 4)) && (tl_h2d_i.a_address[1:0] == 2'b00);
        exp_err = 1'b1;
        exp_data = '0;
        if (tl_h2d_i.a_opcode == tlul_pkg::OP_GET) begin
          if (coef_hit) begin
            exp_err = 1'b0;
            exp_data = 32'(coef_m[idx]);  // sign extended
          end else if (tl_h2d_i.a_address == 8'h40) begin
            exp_err = 1'b0;
            exp_data = 32'(drops_m);
          end else if (tl_h2d_i.a_address == 8'h44) begin
            exp_err = 1'b0;
            exp_data = last_res_m[31:0];
          end
        end else if (tl_h2d_i.a_opcode == tlul_pkg::OP_PUT_FULL && coef_hit) begin
          exp_err = 1'b0;
          coef_m[idx] = $signed(tl_h2d_i.a_data[15:0]);  // low half only
        end
        exp_has_data = (tl_h2d_i.a_opcode == tlul_pkg::OP_GET) && !exp_err;
        exp_op = exp_has_data ? tlul_pkg::OP_ACK_DATA : tlul_pkg::OP_ACK;
      end
      // results due on this edge
      if (exp_due_q.size() > 0 && exp_due_q[0] == cyc) begin
        want = exp_val_q.pop_front();
        void'(exp_due_q.pop_front());
        last_res_m = want;
        if (!result_valid_i) begin
          other_error($sformatf("result_valid_o missing %0d cycles after its strobe", LAT));
        end else begin
          results++;
          if (longint'(result_i) != want) value_error("result_o", result_i, want);
        end
      end else if (result_valid_i) begin
        other_error("result_valid_o without a pending strobe");
      end
      // strobe model, busy for LAT cycles after each accepted one
      if (sample_valid_i) begin
        if (cyc - last_acc_cyc > LAT) begin
          last_acc_cyc = cyc;
          for (int k = N - 1; k > 0; k--) hist_m[k] = hist_m[k-1];
          hist_m[0] = sample_i;
          sum = 0;
          for (int k = 0; k < N; k++) sum += coef_m[k] * hist_m[k];
          exp_val_q.push_back(sum);
          exp_due_q.push_back(cyc + LAT);
        end else if (drops_m < 16'hffff) begin
          drops_m++;  // overrun saturates
        end
      end
    end
  end

  assign value_errs_o = value_errs;
  assign other_errs_o = other_errs;
  assign results_o    = results;
  assign responses_o  = responses;

endmodule

/* tb/tb_fir_parallel.sv */
module tb_fir_parallel;
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [31:0] SEED = 32'hb5724aea;
  localparam int N_SAMPLES = 200;  // spaced 7 to 10 cycles
  localparam int N_BURST   = 24;   // spaced 2 cycles
  localparam int N_TAIL    = 8;
  localparam int N_BUS_OPS = 60;   // upper bound over all tests
  localparam int WATCHDOG_CYCLES = (N_SAMPLES + N_BURST + N_TAIL) * 10 + N_BUS_OPS * 8 + 200;

  logic              clk;
  logic              rst_n;
  fir_pkg::sample_t  sample;
  logic              sample_valid;
  tlul_pkg::tl_h2d_t tl_h2d;
  tlul_pkg::tl_d2h_t tl_d2h;
  fir_pkg::result_t  result;
  logic              result_valid;
  logic [31:0]       lcg_state;
  int                value_errs;
  int                other_errs;
  int                results_seen;
  int                responses_seen;

  fir_parallel dut0 (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .sample_i       (sample),
    .sample_valid_i (sample_valid),
    .tl_i           (tl_h2d),
    .tl_o           (tl_d2h),
    .result_o       (result),
    .result_valid_o (result_valid)
  );

  fir_checker u_checker (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .sample_i       (sample),
    .sample_valid_i (sample_valid),
    .tl_h2d_i       (tl_h2d),
    .tl_d2h_i       (tl_d2h),
    .result_i       (result),
    .result_valid_i (result_valid),
    .value_errs_o   (value_errs),
    .other_errs_o   (other_errs),
    .results_o      (results_seen),
    .responses_o    (responses_seen)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // one request, response taken after a random stall
  task automatic bus_access(input logic [2:0] op, input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] r;
    @(negedge clk);
    tl_h2d.a_valid   = 1'b1;
    tl_h2d.a_opcode  = op;
    tl_h2d.a_address = addr;
    tl_h2d.a_data    = data;
    tl_h2d.d_ready   = 1'b0;
    while (!tl_d2h.a_ready) @(negedge clk);
    @(negedge clk);  // accepted on the edge just passed
    tl_h2d.a_valid = 1'b0;
    while (!tl_d2h.d_valid) @(negedge clk);
    r = next_random();
    repeat (int'(r[31:30]) % 3) @(negedge clk);
    tl_h2d.d_ready = 1'b1;
    @(negedge clk);
    tl_h2d.d_ready = 1'b0;
  endtask

  task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
    bus_access(tlul_pkg::OP_PUT_FULL, addr, data);
  endtask

  task automatic bus_read(input logic [7:0] addr);
    bus_access(tlul_pkg::OP_GET, addr, '0);
  endtask

  // strobe now, next one spacing cycles later, spacing >= 2
  task automatic send_sample(input int spacing);
    logic [31:0] r;
    @(negedge clk);
    r = next_random();
    sample       = r[31:16];
    sample_valid = 1'b1;
    @(negedge clk);
    sample_valid = 1'b0;
    repeat (spacing - 2) @(negedge clk);
  endtask

  task automatic wait_idle();
    repeat (fir_pkg::LATENCY + 2) @(negedge clk);
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("run timed out after %0d cycles", WATCHDOG_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    logic [31:0] r;
    rst_n        = 1'b0;
    sample       = '0;
    sample_valid = 1'b0;
    tl_h2d       = '0;
    lcg_state    = SEED;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // reset values
    for (int k = 0; k < fir_pkg::NUM_TAPS; k++) bus_read(8'(k * 4));
    bus_read(8'h40);
    bus_read(8'h44);
    // random coefficients, junk in the upper half
    for (int k = 0; k < fir_pkg::NUM_TAPS; k++) begin
      r = next_random();
      bus_write(8'(k * 4), r);
    end
    for (int k = 0; k < fir_pkg::NUM_TAPS; k++) bus_read(8'(k * 4));
    // spaced samples, no overrun
    for (int n = 0; n < N_SAMPLES; n++) begin
      r = next_random();
      send_sample(7 + int'(r[31:30]));
    end
    wait_idle();
    // burst, most strobes land in a busy window
    for (int n = 0; n < N_BURST; n++) send_sample(2);
    wait_idle();
    bus_read(8'h40);
    bus_read(8'h44);  // last result, low word
    // unmapped and read-only accesses, then a normal write
    bus_read(8'h48);
    bus_read(8'h80);
    bus_write(8'h40, 32'h0000_1234);
    r = next_random();
    bus_write(8'h14, r);
    bus_read(8'h14);
    for (int n = 0; n < N_TAIL; n++) send_sample(7);
    wait_idle();
    $display("checker: %0d value errors, %0d other errors, %0d results, %0d bus responses",
             value_errs, other_errs, results_seen, responses_seen);
    if (results_seen == 0) $display("no filter results were seen");
    if (value_errs == 0 && other_errs == 0 && results_seen > 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* sim.f */
hdl/fir_pkg.sv
hdl/tlul_pkg.sv
hdl/fir_reg_port.sv
hdl/fir_sample_line.sv
hdl/fir_lane.sv
hdl/fir_sum_stage.sv
hdl/fir_parallel.sv
tb/fir_checker.sv
tb/tb_fir_parallel.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the FIR testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_fir_parallel -f sim.f -o tb_fir_parallel
./obj_dir/tb_fir_parallel > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "TB FAILED" "$LOG"; then
  echo "simulation failed, see $LOG"
  exit 1
fi
if ! grep -q "TB PASSED" "$LOG"; then
  echo "simulation ended without a result, see $LOG"
  exit 1
fi
echo "simulation passed"
